/* logic/acq_pkg.sv */
package acq_pkg;

    // one circular buffer word holds two 12-bit samples
    localparam int SAMPLE_WORD_W = 32;

    // buffer words gathered into one data burst
    localparam int WORDS_PER_BURST = 4;

    // record payload width, one burst wide
    localparam int REC_W = SAMPLE_WORD_W * WORDS_PER_BURST;

    // kinds of records written into the output FIFO
    typedef enum logic [1:0] {
        REC_FILL_HDR,
        REC_WFM_HDR,
        REC_DATA,
        REC_CHECKSUM
    } rec_kind_e;

    // one record as it leaves the channel
    typedef struct packed {
        rec_kind_e        kind;
        logic [REC_W-1:0] payload;
    } acq_record_t;

    // strobes from the sequencer to the datapath
    typedef struct packed {
        // record kind for header and checksum strobes
        rec_kind_e sel;
        logic      rec_strobe;
        logic      rd_init;
        logic      rd_inc;
        logic      burst_load;
        logic      burst_dec;
        logic      fill_inc;
        logic      cksum_clear;
    } acq_ctrl_t;

endpackage

/* logic/acq_input_sync.sv */
module acq_input_sync #(
    parameter int SYNC_STAGES = 4
) (
    input  logic       clk,
    input  logic       adc_acq_full_reset,
    input  logic [1:0] acq_enable,
    input  logic       acq_trig,
    input  logic       ddr3_wr_done,
    output logic       mode_enabled,
    output logic [1:0] fill_type,
    output logic       trig_level,
    output logic       wr_done_sync
);

    // enable chain is one stage short, the mode register makes up the last stage
    logic [SYNC_STAGES-2:0][1:0] en_sync;
    logic [SYNC_STAGES-1:0]      trig_sync;
    // ddr3 done is a slow level, two stages are enough
    logic [1:0]                  done_sync;

    always_ff @(posedge clk) begin
        if (adc_acq_full_reset) begin
            en_sync      <= '0;
            trig_sync    <= '0;
            done_sync    <= '0;
            mode_enabled <= 1'b0;
            fill_type    <= 2'b00;
        end else begin
            en_sync[0]   <= acq_enable;
            trig_sync[0] <= acq_trig;
            for (int i = 1; i < SYNC_STAGES - 1; i++) begin
                en_sync[i] <= en_sync[i-1];
            end
            for (int i = 1; i < SYNC_STAGES; i++) begin
                trig_sync[i] <= trig_sync[i-1];
            end
            done_sync <= {done_sync[0], ddr3_wr_done};
            // armed whenever either enable bit is set
            mode_enabled <= |en_sync[SYNC_STAGES-2];
            // both enable bits together select the fill type
            fill_type    <= en_sync[SYNC_STAGES-2];
        end
    end

    assign trig_level   = trig_sync[SYNC_STAGES-1];
    assign wr_done_sync = done_sync[1];

endmodule

/* logic/acq_sequencer.sv */
module acq_sequencer (
    input  logic              clk,
    input  logic              adc_acq_full_reset,
    input  logic              mode_enabled,
    input  logic              trig_level,
    input  logic              wr_done_sync,
    input  logic              trig_fifo_empty,
    input  logic              burst_last,
    output acq_pkg::acq_ctrl_t ctrl,
    output logic              trig_addr_rd_en,
    output logic              acq_enabled,
    output logic              sm_idle,
    output logic              acq_done
);

    import acq_pkg::*;

    typedef enum logic [3:0] {
        IDLE,
        WATCH_FOR_TRIG,
        FILL_INIT1,
        FILL_INIT2,
        WFM_INIT1,
        WFM_INIT2,
        RUN1,
        RUN2,
        RUN3,
        RUN4,
        WFM_END,
        CHECKSUM,
        DDR3_WAIT,
        DONE
    } state_e;

    state_e    state;
    state_e    state_next;
    acq_ctrl_t ctrl_next;

    always_comb begin
        state_next = state;
        case (state)
            IDLE: begin
                if (mode_enabled) begin
                    state_next = WATCH_FOR_TRIG;
                end
            end
            // a trigger address in the FIFO starts the fill
            WATCH_FOR_TRIG: begin
                if (!trig_fifo_empty) begin
                    state_next = FILL_INIT1;
                end else if (!mode_enabled) begin
                    state_next = IDLE;
                end
            end
            FILL_INIT1: state_next = FILL_INIT2;
            FILL_INIT2: state_next = WFM_INIT1;
            WFM_INIT1:  state_next = WFM_INIT2;
            WFM_INIT2:  state_next = RUN1;
            // one buffer word read per RUN state
            RUN1:       state_next = RUN2;
            RUN2:       state_next = RUN3;
            RUN3:       state_next = RUN4;
            RUN4:       state_next = burst_last ? WFM_END : RUN1;
            // last burst is still coming back from the buffer here
            WFM_END:    state_next = CHECKSUM;
            CHECKSUM:   state_next = DDR3_WAIT;
            DDR3_WAIT: begin
                if (wr_done_sync) begin
                    state_next = DONE;
                end
            end
            // hold while the trigger stays high so one trigger gives one fill
            DONE: begin
                if (!(mode_enabled && trig_level)) begin
                    state_next = IDLE;
                end
            end
            default:    state_next = IDLE;
        endcase
    end

    // strobes are decoded from the state being entered
    always_comb begin
        ctrl_next     = '0;
        ctrl_next.sel = REC_DATA;
        case (state_next)
            FILL_INIT1: ctrl_next.cksum_clear = 1'b1;
            FILL_INIT2: begin
                ctrl_next.sel        = REC_FILL_HDR;
                ctrl_next.rec_strobe = 1'b1;
            end
            WFM_INIT1: begin
                ctrl_next.rd_init    = 1'b1;
                ctrl_next.burst_load = 1'b1;
            end
            WFM_INIT2: begin
                ctrl_next.sel        = REC_WFM_HDR;
                ctrl_next.rec_strobe = 1'b1;
            end
            RUN1: begin
                ctrl_next.rd_inc    = 1'b1;
                ctrl_next.burst_dec = 1'b1;
            end
            RUN2, RUN3, RUN4: ctrl_next.rd_inc = 1'b1;
            CHECKSUM: begin
                ctrl_next.sel        = REC_CHECKSUM;
                ctrl_next.rec_strobe = 1'b1;
                ctrl_next.fill_inc   = 1'b1;
            end
            default: ;
        endcase
    end

    always_ff @(posedge clk) begin
        if (adc_acq_full_reset) begin
            state           <= IDLE;
            ctrl            <= '0;
            trig_addr_rd_en <= 1'b0;
            acq_enabled     <= 1'b0;
            sm_idle         <= 1'b1;
            acq_done        <= 1'b0;
        end else begin
            state           <= state_next;
            ctrl            <= ctrl_next;
            // FWFT FIFO so the address is already on trig_addr when popped
            trig_addr_rd_en <= (state_next == WFM_INIT1);
            acq_enabled     <= !(state_next inside {IDLE, WATCH_FOR_TRIG});
            sm_idle         <= (state_next inside {IDLE, WATCH_FOR_TRIG});
            acq_done        <= (state_next == DONE);
        end
    end

    // trigger FIFO must still hold the address three cycles after it was seen
    a_pop_not_empty: assert property (@(posedge clk) disable iff (adc_acq_full_reset)
        trig_addr_rd_en |-> !trig_fifo_empty);

endmodule

/* logic/acq_counters.sv */
module acq_counters #(
    parameter int BURST_CNT_W = 12
) (
    input  logic                   clk,
    input  logic                   adc_acq_full_reset,
    input  acq_pkg::acq_ctrl_t     ctrl,
    input  logic [BURST_CNT_W-1:0] burst_count,
    output logic                   burst_last,
    output logic [23:0]            fill_num
);

    // bursts still to read after the one in progress
    logic [BURST_CNT_W-1:0] burst_cnt;

    always_ff @(posedge clk) begin
        if (adc_acq_full_reset) begin
            burst_cnt <= '0;
            fill_num  <= '0;
        end else begin
            if (ctrl.burst_load) begin
                burst_cnt <= burst_count;
            end else if (ctrl.burst_dec) begin
                burst_cnt <= burst_cnt - 1'b1;
            end
            // one count per fill, bumped with the checksum record
            if (ctrl.fill_inc) begin
                fill_num <= fill_num + 1'b1;
            end
        end
    end

    // decrement lands in RUN1 so RUN4 sees the count for the burst being read
    assign burst_last = (burst_cnt == '0);

    // a zero burst count on the port would wrap the countdown
    a_no_underflow: assert property (@(posedge clk) disable iff (adc_acq_full_reset)
        ctrl.burst_dec |-> (burst_cnt != '0));

endmodule

/* logic/circ_buf_reader.sv */
module circ_buf_reader #(
    parameter int BUF_ADDR_W = 10
) (
    input  logic                              clk,
    input  logic                              adc_acq_full_reset,
    input  acq_pkg::acq_ctrl_t                ctrl,
    input  logic [BUF_ADDR_W-1:0]             trig_addr,
    input  logic [acq_pkg::SAMPLE_WORD_W-1:0] circ_buf_rd_data,
    output logic [BUF_ADDR_W-1:0]             circ_buf_rd_addr,
    output logic                              circ_buf_rd_en,
    output logic [acq_pkg::REC_W-1:0]         burst_data,
    output logic                              burst_valid
);

    import acq_pkg::*;

    logic [BUF_ADDR_W-1:0]                               rd_addr;
    // marks the cycle the buffer returns a word
    logic                                                rd_inc_q;
    logic [$clog2(WORDS_PER_BURST)-1:0]                  lane_idx;
    // first three lanes are held, the fourth comes straight from the buffer
    logic [WORDS_PER_BURST-2:0][SAMPLE_WORD_W-1:0]       lanes;

    always_ff @(posedge clk) begin
        if (adc_acq_full_reset) begin
            rd_addr  <= '0;
            rd_inc_q <= 1'b0;
            lane_idx <= '0;
        end else begin
            if (ctrl.rd_init) begin
                rd_addr  <= trig_addr;
                lane_idx <= '0;
            end else if (ctrl.rd_inc) begin
                // natural wrap at the top of the buffer
                rd_addr <= rd_addr + 1'b1;
            end
            rd_inc_q <= ctrl.rd_inc;
            if (rd_inc_q) begin
                lane_idx <= lane_idx + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rd_inc_q && (lane_idx != WORDS_PER_BURST - 1)) begin
            lanes[lane_idx] <= circ_buf_rd_data;
        end
    end

    assign circ_buf_rd_addr = rd_addr;
    assign circ_buf_rd_en   = ctrl.rd_inc;
    // first word read sits in the low lane
    assign burst_data  = {circ_buf_rd_data, lanes};
    assign burst_valid = rd_inc_q && (lane_idx == WORDS_PER_BURST - 1);

    // address load needs a cycle before the first read
    a_init_gap: assert property (@(posedge clk) disable iff (adc_acq_full_reset)
        ctrl.rd_init |=> !ctrl.rd_inc);

endmodule

/* logic/record_mux.sv */
module record_mux #(
    parameter int BUF_ADDR_W  = 10,
    parameter int BURST_CNT_W = 12
) (
    input  logic                      clk,
    input  logic                      adc_acq_full_reset,
    input  acq_pkg::acq_ctrl_t        ctrl,
    input  logic [1:0]                fill_type,
    input  logic [23:0]               fill_num,
    input  logic [BUF_ADDR_W-1:0]     trig_addr,
    input  logic [BURST_CNT_W-1:0]    burst_count,
    input  logic [acq_pkg::REC_W-1:0] burst_data,
    input  logic                      burst_valid,
    output logic                      rec_valid,
    output acq_pkg::acq_record_t      rec
);

    import acq_pkg::*;

    // trigger FIFO is popped before the waveform header goes out
    logic [BUF_ADDR_W-1:0]                         trig_addr_q;
    logic [SAMPLE_WORD_W-1:0]                      cksum;
    logic [SAMPLE_WORD_W-1:0]                      lane_sum;
    logic [WORDS_PER_BURST-1:0][SAMPLE_WORD_W-1:0] hdr_lanes;
    acq_record_t                                   rec_next;
    logic                                          emit;

    always_comb begin
        hdr_lanes = '0;
        case (ctrl.sel)
            REC_FILL_HDR: begin
                hdr_lanes[0] = SAMPLE_WORD_W'(fill_num);
                hdr_lanes[1] = SAMPLE_WORD_W'(fill_type);
                hdr_lanes[2] = SAMPLE_WORD_W'(burst_count);
            end
            REC_WFM_HDR: begin
                hdr_lanes[0] = SAMPLE_WORD_W'(trig_addr_q);
                hdr_lanes[1] = SAMPLE_WORD_W'(burst_count);
            end
            REC_CHECKSUM: hdr_lanes[0] = cksum;
            default: ;
        endcase
        // data bursts and strobed records never share a cycle
        rec_next.kind    = burst_valid ? REC_DATA : ctrl.sel;
        rec_next.payload = burst_valid ? burst_data : hdr_lanes;
        lane_sum = '0;
        for (int i = 0; i < WORDS_PER_BURST; i++) begin
            lane_sum = lane_sum + rec_next.payload[i*SAMPLE_WORD_W +: SAMPLE_WORD_W];
        end
    end

    assign emit = burst_valid || ctrl.rec_strobe;

    always_ff @(posedge clk) begin
        if (adc_acq_full_reset) begin
            rec_valid <= 1'b0;
            cksum     <= '0;
        end else begin
            rec_valid <= emit;
            if (ctrl.cksum_clear) begin
                cksum <= '0;
            end else if (emit && (rec_next.kind != REC_CHECKSUM)) begin
                // modular sum of every lane emitted so far in the fill
                cksum <= cksum + lane_sum;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (emit) begin
            rec <= rec_next;
        end
        if (ctrl.rd_init) begin
            trig_addr_q <= trig_addr;
        end
    end

    // sequencer timing keeps strobes clear of the burst completion cycles
    a_no_collision: assert property (@(posedge clk) disable iff (adc_acq_full_reset)
        !(burst_valid && ctrl.rec_strobe));

endmodule

/* logic/adc_acq_top.sv */
module adc_acq_top #(
    parameter int SYNC_STAGES = 4,
    parameter int BUF_ADDR_W  = 10,
    parameter int BURST_CNT_W = 12
) (
    input  logic                              clk,
    input  logic                              adc_acq_full_reset,
    input  logic [1:0]                        acq_enable,
    input  logic                              acq_trig,
    input  logic                              trig_fifo_empty,
    input  logic [BUF_ADDR_W-1:0]             trig_addr,
    input  logic [BURST_CNT_W-1:0]            burst_count,
    input  logic                              ddr3_wr_done,
    input  logic [acq_pkg::SAMPLE_WORD_W-1:0] circ_buf_rd_data,
    output logic                              trig_addr_rd_en,
    output logic [BUF_ADDR_W-1:0]             circ_buf_rd_addr,
    output logic                              circ_buf_rd_en,
    output logic                              rec_valid,
    output acq_pkg::acq_record_t              rec,
    output logic                              acq_enabled,
    output logic                              sm_idle,
    output logic                              acq_done
);

    import acq_pkg::*;

    logic             mode_enabled;
    logic [1:0]       fill_type;
    logic             trig_level;
    logic             wr_done_sync;
    acq_ctrl_t        ctrl;
    logic             burst_last;
    logic [23:0]      fill_num;
    logic [REC_W-1:0] burst_data;
    logic             burst_valid;

    acq_input_sync #(
        .SYNC_STAGES(SYNC_STAGES)
    ) u_input_sync (
        .clk, .adc_acq_full_reset, .acq_enable, .acq_trig, .ddr3_wr_done,
        .mode_enabled, .fill_type, .trig_level, .wr_done_sync
    );

    acq_sequencer u_sequencer (
        .clk, .adc_acq_full_reset, .mode_enabled, .trig_level, .wr_done_sync,
        .trig_fifo_empty, .burst_last, .ctrl, .trig_addr_rd_en, .acq_enabled,
        .sm_idle, .acq_done
    );

    acq_counters #(
        .BURST_CNT_W(BURST_CNT_W)
    ) u_counters (
        .clk, .adc_acq_full_reset, .ctrl, .burst_count, .burst_last, .fill_num
    );

    circ_buf_reader #(
        .BUF_ADDR_W(BUF_ADDR_W)
    ) u_reader (
        .clk, .adc_acq_full_reset, .ctrl, .trig_addr, .circ_buf_rd_data,
        .circ_buf_rd_addr, .circ_buf_rd_en, .burst_data, .burst_valid
    );

    record_mux #(
        .BUF_ADDR_W (BUF_ADDR_W),
        .BURST_CNT_W(BURST_CNT_W)
    ) u_record_mux (
        .clk, .adc_acq_full_reset, .ctrl, .fill_type, .fill_num, .trig_addr,
        .burst_count, .burst_data, .burst_valid, .rec_valid, .rec
    );

endmodule

/* verification/tb_adc_acq.sv */
module tb_adc_acq;

    timeunit 1ns;
    timeprecision 1ps;

    import acq_pkg::*;

    localparam int SYNC_STAGES = 4;
    localparam int BUF_ADDR_W  = 10;
    localparam int BURST_CNT_W = 12;
    localparam int BUF_DEPTH   = 1 << BUF_ADDR_W;
    localparam int CLK_PERIOD  = 4;
    localparam int MAX_BURSTS  = 6;
    localparam int NUM_FILLS   = 9;
    // per fill allowance plus the fixed idle, arm and hold waits
    localparam int WATCHDOG_CYCLES = NUM_FILLS * (MAX_BURSTS * 4 + 60) + 400;

    logic                     clk = 1'b0;
    logic                     adc_acq_full_reset = 1'b1;
    logic [1:0]               acq_enable;
    logic                     acq_trig;
    logic                     trig_fifo_empty;
    logic [BUF_ADDR_W-1:0]    trig_addr;
    logic [BURST_CNT_W-1:0]   burst_count;
    logic                     ddr3_wr_done;
    logic [SAMPLE_WORD_W-1:0] circ_buf_rd_data;
    logic                     trig_addr_rd_en;
    logic [BUF_ADDR_W-1:0]    circ_buf_rd_addr;
    logic                     circ_buf_rd_en;
    logic                     rec_valid;
    acq_record_t              rec;
    logic                     acq_enabled;
    logic                     sm_idle;
    logic                     acq_done;

    // trigger FIFO contents and the records still to come
    logic [BUF_ADDR_W-1:0] trig_q[$];
    acq_record_t           exp_q[$];
    acq_record_t           exp_rec;
    integer                seed;
    int                    fill_cnt = 0;
    int                    done_count = 0;
    int                    pop_count = 0;
    int                    ddr_countdown = 0;
    // requests seen mid-cycle and served after the next rising edge
    logic                  rd_pending = 1'b0;
    logic                  pop_pending = 1'b0;
    logic [BUF_ADDR_W-1:0] rd_addr_q = '0;
    logic                  done_q = 1'b0;
    logic                  ddr_raised = 1'b0;
    logic [1:0]            cur_type;
    int                    cur_bursts;
    logic [BUF_ADDR_W-1:0] held_addr;

    adc_acq_top #(
        .SYNC_STAGES(SYNC_STAGES),
        .BUF_ADDR_W (BUF_ADDR_W),
        .BURST_CNT_W(BURST_CNT_W)
    ) DUT (
        .clk, .adc_acq_full_reset, .acq_enable, .acq_trig, .trig_fifo_empty, .trig_addr,
        .burst_count, .ddr3_wr_done, .circ_buf_rd_data, .trig_addr_rd_en,
        .circ_buf_rd_addr, .circ_buf_rd_en, .rec_valid, .rec, .acq_enabled, .sm_idle,
        .acq_done
    );

    initial begin
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    task automatic check_value(input logic [127:0] got, input logic [127:0] expected,
                               input string what);
        if (got !== expected) begin
            $display("error at %0t ns: %s, got %0h expected %0h", $time, what, got, expected);
            $display("Test failed");
            $fatal(1, "check mismatch");
        end
    endtask

    // odd multiplier keeps every buffer word distinct
    function automatic logic [SAMPLE_WORD_W-1:0] buf_word(input logic [BUF_ADDR_W-1:0] addr);
        return (32'(addr) * 32'h9e37_79b1) ^ 32'h5a5a_0000;
    endfunction

    function automatic logic [SAMPLE_WORD_W-1:0] sum_lanes(input logic [REC_W-1:0] p);
        logic [SAMPLE_WORD_W-1:0] s;
        s = '0;
        for (int i = 0; i < WORDS_PER_BURST; i++) begin
            s = s + p[i*SAMPLE_WORD_W +: SAMPLE_WORD_W];
        end
        return s;
    endfunction

    // expected record sequence of one fill
    function automatic void build_fill(input logic [23:0] fnum, input logic [1:0] ftype,
                                       input logic [BUF_ADDR_W-1:0] addr, input int bursts);
        acq_record_t              r;
        logic [SAMPLE_WORD_W-1:0] sum;
        int                       word_addr;
        sum = '0;
        r.kind = REC_FILL_HDR;
        r.payload = '0;
        r.payload[31:0]  = 32'(fnum);
        r.payload[63:32] = 32'(ftype);
        r.payload[95:64] = 32'(bursts);
        sum = sum + sum_lanes(r.payload);
        exp_q.push_back(r);
        r.kind = REC_WFM_HDR;
        r.payload = '0;
        r.payload[31:0]  = 32'(addr);
        r.payload[63:32] = 32'(bursts);
        sum = sum + sum_lanes(r.payload);
        exp_q.push_back(r);
        r.kind = REC_DATA;
        for (int b = 0; b < bursts; b++) begin
            for (int w = 0; w < WORDS_PER_BURST; w++) begin
                // reads wrap at the top of the buffer
                word_addr = (int'(addr) + b * WORDS_PER_BURST + w) % BUF_DEPTH;
                r.payload[w*SAMPLE_WORD_W +: SAMPLE_WORD_W] = buf_word(BUF_ADDR_W'(word_addr));
            end
            sum = sum + sum_lanes(r.payload);
            exp_q.push_back(r);
        end
        r.kind = REC_CHECKSUM;
        r.payload = '0;
        r.payload[31:0] = sum;
        exp_q.push_back(r);
    endfunction

    function automatic logic [BUF_ADDR_W-1:0] rand_addr();
        return BUF_ADDR_W'($random(seed));
    endfunction

    function automatic int rand_bursts();
        return 1 + int'($unsigned($random(seed)) % MAX_BURSTS);
    endfunction

    task automatic set_fill_mode(input logic [1:0] ftype, input int bursts);
        @(posedge clk);
        #1;
        acq_enable  = ftype;
        burst_count = BURST_CNT_W'(bursts);
        cur_type    = ftype;
        cur_bursts  = bursts;
    endtask

    // expected records go in before the address reaches the FIFO
    task automatic queue_fill(input logic [BUF_ADDR_W-1:0] addr, input logic push);
        @(posedge clk);
        #1;
        build_fill(24'(fill_cnt), cur_type, addr, cur_bursts);
        fill_cnt++;
        if (push) begin
            @(negedge clk);
            trig_q.push_back(addr);
        end
    endtask

    task automatic wait_fills_done();
        while (done_count < fill_cnt) begin
            @(posedge clk);
        end
        check_value(exp_q.size(), 0, "records missing at acq_done");
    endtask

    // one cycle with no fill under way
    task automatic check_waiting(input string what);
        @(negedge clk);
        check_value(acq_enabled, 1'b0, {"acq_enabled ", what});
        check_value(sm_idle, 1'b1, {"sm_idle ", what});
    endtask

    // buffer and FIFO requests are sampled mid-cycle
    always @(negedge clk) begin
        rd_pending  = circ_buf_rd_en;
        rd_addr_q   = circ_buf_rd_addr;
        pop_pending = trig_addr_rd_en;
        if (trig_addr_rd_en === 1'b1) begin
            pop_count++;
        end
    end

    // memory, FWFT FIFO and DDR3 writer answers
    always @(posedge clk) begin
        #1;
        // one cycle read latency
        if (rd_pending) begin
            circ_buf_rd_data = buf_word(rd_addr_q);
        end
        if (pop_pending) begin
            trig_q.delete(0);
        end
        trig_fifo_empty = (trig_q.size() == 0);
        trig_addr = (trig_q.size() != 0) ? trig_q[0] : '0;
        if (ddr_countdown > 0) begin
            ddr_countdown--;
            if (ddr_countdown == 0) begin
                ddr3_wr_done = 1'b1;
                ddr_raised   = 1'b1;
            end
        end
        // writer drops done once the channel acknowledges
        if (done_q) begin
            ddr3_wr_done = 1'b0;
        end
    end

    // record compare and status checks
    always @(negedge clk) begin
        if (adc_acq_full_reset === 1'b0) begin
            check_value(acq_done && !ddr_raised, 1'b0, "acq_done before ddr3_wr_done");
            if (rec_valid) begin
                if (exp_q.size() == 0) begin
                    $display("a record appeared at %0t ns while no fill was expected", $time);
                    $display("Test failed");
                    $fatal(1, "unexpected record");
                end else begin
                    exp_rec = exp_q.pop_front();
                    check_value(rec.kind, exp_rec.kind, "record kind");
                    check_value(rec.payload, exp_rec.payload, "record payload");
                    check_value(acq_enabled, 1'b1, "acq_enabled during record");
                    if (exp_rec.kind == REC_FILL_HDR) begin
                        ddr_raised = 1'b0;
                    end
                    // writer finishes a few cycles after the checksum
                    if (exp_rec.kind == REC_CHECKSUM) begin
                        ddr_countdown = 4;
                    end
                end
            end
            if (acq_done && !done_q) begin
                done_count++;
            end
            done_q = acq_done;
        end
    end

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("timeout at %0t ns, the run did not end within %0d cycles",
                 $time, WATCHDOG_CYCLES);
        $display("Test failed");
        $fatal(1, "watchdog expired");
    end

    initial begin
        seed               = 39967;
        adc_acq_full_reset = 1'b1;
        acq_enable         = 2'b00;
        acq_trig           = 1'b0;
        trig_fifo_empty    = 1'b1;
        trig_addr          = '0;
        burst_count        = '0;
        ddr3_wr_done       = 1'b0;
        circ_buf_rd_data   = '0;
        cur_type           = 2'b00;
        cur_bursts         = 1;
        repeat (5) @(posedge clk);
        #1;
        adc_acq_full_reset = 1'b0;
        @(negedge clk);
        check_value(sm_idle, 1'b1, "sm_idle after reset");
        check_value(acq_enabled, 1'b0, "acq_enabled after reset");
        check_value(acq_done, 1'b0, "acq_done after reset");
        check_value(rec_valid, 1'b0, "rec_valid after reset");
        check_value(trig_addr_rd_en, 1'b0, "trig_addr_rd_en after reset");
        check_value(circ_buf_rd_en, 1'b0, "circ_buf_rd_en after reset");

        // trigger waits in the FIFO while disabled
        held_addr = rand_addr();
        trig_q.push_back(held_addr);
        repeat (30) check_waiting("while disabled");
        check_value(pop_count, 0, "FIFO popped while disabled");

        // arming starts the fill from the queued address
        set_fill_mode(2'd1, rand_bursts());
        queue_fill(held_addr, 1'b0);
        wait_fills_done();

        for (int t = 2; t <= 3; t++) begin
            set_fill_mode(2'(t), rand_bursts());
            repeat (SYNC_STAGES + 2) @(posedge clk);
            check_waiting("while waiting for a trigger");
            queue_fill(rand_addr(), 1'b1);
            wait_fills_done();
        end

        // sixteen words from five below the top cross the wrap
        set_fill_mode(2'd3, 4);
        repeat (SYNC_STAGES + 2) @(posedge clk);
        check_waiting("while waiting for a trigger");
        queue_fill(BUF_ADDR_W'(BUF_DEPTH - 5), 1'b1);
        wait_fills_done();

        // back-to-back fills from a filled FIFO
        set_fill_mode(2'd1, rand_bursts());
        repeat (SYNC_STAGES + 2) @(posedge clk);
        check_waiting("while waiting for a trigger");
        repeat (3) queue_fill(rand_addr(), 1'b1);
        wait_fills_done();

        // trigger held high keeps the machine in DONE
        set_fill_mode(2'd2, rand_bursts());
        @(posedge clk);
        #1;
        acq_trig = 1'b1;
        repeat (SYNC_STAGES + 2) @(posedge clk);
        check_waiting("while waiting for a trigger");
        queue_fill(rand_addr(), 1'b1);
        wait_fills_done();
        held_addr = rand_addr();
        @(negedge clk);
        trig_q.push_back(held_addr);
        repeat (20) begin
            @(negedge clk);
            check_value(acq_done, 1'b1, "acq_done with trigger held");
            check_value(acq_enabled, 1'b1, "acq_enabled with trigger held");
            check_value(sm_idle, 1'b0, "sm_idle with trigger held");
        end
        @(posedge clk);
        check_value(pop_count, fill_cnt, "FIFO popped while held in DONE");

        // dropping the trigger lets the waiting address run
        queue_fill(held_addr, 1'b0);
        @(posedge clk);
        #1;
        acq_trig = 1'b0;
        wait_fills_done();
        repeat (10) @(posedge clk);
        check_value(pop_count, fill_cnt, "one FIFO pop per fill");
        $display("Test completed successfully");
        $finish;
    end

endmodule

/* verilog.f */
logic/acq_pkg.sv
logic/acq_input_sync.sv
logic/acq_sequencer.sv
logic/acq_counters.sv
logic/circ_buf_reader.sv
logic/record_mux.sv
logic/adc_acq_top.sv
verification/tb_adc_acq.sv

/* Bender.yml */
package:
  name: adc_acq

sources:
  - logic/acq_pkg.sv
  - logic/acq_input_sync.sv
  - logic/acq_sequencer.sv
  - logic/acq_counters.sv
  - logic/circ_buf_reader.sv
  - logic/record_mux.sv
  - logic/adc_acq_top.sv
  - target: test
    files:
      - verification/tb_adc_acq.sv
